// ==== logic/wb_addr_decode.sv ====
`timescale 1ns/100ps

module wb_addr_decode #(
  parameter bit REMAP_EN = 1'b0
) (
  input  logic [wb_bus_pkg::WB_ADR_W-1:0] adr_i,
  input  logic [wb_map_pkg::REMAP_W-1:0]  boot_remap_i,
  output logic [wb_bus_pkg::WB_TID_W-1:0] tid_o
);
  import wb_map_pkg::*;

  wb_addr_u adr_u;

  assign adr_u = adr_i;

  always_comb begin
    // Anything unmapped lands on target 0
    tid_o = TGT_QSPI;
    // Boot remap wins over the region map
    if (REMAP_EN && boot_remap_i[0] && adr_u.remap_v.page == 21'd0) begin
      tid_o = TGT_MBIST1;
    end else if (REMAP_EN && boot_remap_i[1] && adr_u.remap_v.page == 21'd1) begin
      tid_o = TGT_MBIST2;
    end else if (adr_u.reg_v.region[15:12] == 4'h0) begin
      // QSPI memory window
      tid_o = TGT_QSPI;
    end else begin
      case (adr_u.reg_v.region)
        REG_QSPI_REG: tid_o = TGT_QSPI;
        REG_UART:     tid_o = TGT_UART;
        REG_PINMUX:   tid_o = TGT_PINMUX;
        REG_MBIST1:   tid_o = TGT_MBIST1;
        REG_MBIST2:   tid_o = TGT_MBIST2;
        default:      tid_o = TGT_QSPI;
      endcase
    end
  end

endmodule

// ==== logic/wb_arb.sv ====
`timescale 1ns/100ps

module wb_arb #(
  parameter int  NUM_MASTERS = wb_bus_pkg::WB_NUM_MST,
  localparam int GNT_W       = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic [NUM_MASTERS-1:0] req_i,
  output logic [GNT_W-1:0]       gnt_o
);

  logic [GNT_W-1:0] gnt_q;
  logic [GNT_W-1:0] gnt_d;

  // ----------------------------------------------------------
  // Next grant
  // ----------------------------------------------------------

  always_comb begin
    // Hold while the owner keeps requesting, or when nobody asks
    gnt_d = gnt_q;
    if (!req_i[gnt_q]) begin
      // Walk from the farthest to the nearest neighbour
      // Nearest requester in rotating order ends up owning the bus
      for (int off = NUM_MASTERS - 1; off > 0; off--) begin
        if (req_i[(int'(gnt_q) + off) % NUM_MASTERS]) begin
          gnt_d = GNT_W'((int'(gnt_q) + off) % NUM_MASTERS);
        end
      end
    end
  end

  // Registered grant, master 0 owns the bus out of reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      gnt_q <= '0;
    end else begin
      gnt_q <= gnt_d;
    end
  end

  assign gnt_o = gnt_q;

endmodule

// ==== logic/wb_bus_pkg.sv ====
package wb_bus_pkg;

  // ----------------------------------------------------------
  // Wishbone data path widths
  // ----------------------------------------------------------

  // Data word and its byte lane selects
  localparam int WB_DAT_W = 32;
  localparam int WB_SEL_W = WB_DAT_W / 8;

  // Byte address as issued by every master
  localparam int WB_ADR_W = 32;

  // Target id travels with the request through the stage
  localparam int WB_TID_W = 3;

  // Host, RISC instruction port and RISC data port
  localparam int WB_NUM_MST = 3;

endpackage

// ==== logic/wb_chan_if.sv ====
`timescale 1ns/100ps

interface wb_chan_if;
  import wb_bus_pkg::*;

  // Request side, held steady until ack
  logic [WB_DAT_W-1:0] dat;
  logic [WB_ADR_W-1:0] adr;
  logic [WB_SEL_W-1:0] sel;
  logic                we;
  logic                cyc;
  logic                stb;
  // Slave chosen by the address decoder
  logic [WB_TID_W-1:0] tid;

  // Response side
  logic [WB_DAT_W-1:0] rdat;
  // Single cycle pulse per transfer
  logic                ack;

  modport initiator (
    output dat, adr, sel, we, cyc, stb, tid,
    input  rdat, ack
  );

  modport target (
    input  dat, adr, sel, we, cyc, stb, tid,
    output rdat, ack
  );

endinterface

// ==== logic/wb_interconnect.sv ====
`timescale 1ns/100ps

module wb_interconnect #(
  parameter int NUM_MASTERS = wb_bus_pkg::WB_NUM_MST
) (
  input  logic                               clk_i,
  input  logic                               reset_i,
  // Low pages of the RISC ports moved onto MBIST memories
  input  logic [wb_map_pkg::REMAP_W-1:0]     boot_remap_i,

  // Master 0 is the external host
  input  logic [wb_bus_pkg::WB_DAT_W-1:0]    m0_wbd_dat_i,
  input  logic [wb_bus_pkg::WB_ADR_W-1:0]    m0_wbd_adr_i,
  input  logic [wb_bus_pkg::WB_SEL_W-1:0]    m0_wbd_sel_i,
  input  logic                               m0_wbd_we_i,
  input  logic                               m0_wbd_cyc_i,
  input  logic                               m0_wbd_stb_i,
  output logic [wb_bus_pkg::WB_DAT_W-1:0]    m0_wbd_dat_o,
  output logic                               m0_wbd_ack_o,

  // Master 1 is the RISC instruction port
  input  logic [wb_bus_pkg::WB_DAT_W-1:0]    m1_wbd_dat_i,
  input  logic [wb_bus_pkg::WB_ADR_W-1:0]    m1_wbd_adr_i,
  input  logic [wb_bus_pkg::WB_SEL_W-1:0]    m1_wbd_sel_i,
  input  logic                               m1_wbd_we_i,
  input  logic                               m1_wbd_cyc_i,
  input  logic                               m1_wbd_stb_i,
  output logic [wb_bus_pkg::WB_DAT_W-1:0]    m1_wbd_dat_o,
  output logic                               m1_wbd_ack_o,

  // Master 2 is the RISC data port
  input  logic [wb_bus_pkg::WB_DAT_W-1:0]    m2_wbd_dat_i,
  input  logic [wb_bus_pkg::WB_ADR_W-1:0]    m2_wbd_adr_i,
  input  logic [wb_bus_pkg::WB_SEL_W-1:0]    m2_wbd_sel_i,
  input  logic                               m2_wbd_we_i,
  input  logic                               m2_wbd_cyc_i,
  input  logic                               m2_wbd_stb_i,
  output logic [wb_bus_pkg::WB_DAT_W-1:0]    m2_wbd_dat_o,
  output logic                               m2_wbd_ack_o,

  // Slave 0 for QSPI memory and registers
  input  logic [wb_bus_pkg::WB_DAT_W-1:0]    s0_wbd_dat_i,
  input  logic                               s0_wbd_ack_i,
  output logic [wb_bus_pkg::WB_DAT_W-1:0]    s0_wbd_dat_o,
  output logic [wb_bus_pkg::WB_ADR_W-1:0]    s0_wbd_adr_o,
  output logic [wb_bus_pkg::WB_SEL_W-1:0]    s0_wbd_sel_o,
  output logic                               s0_wbd_we_o,
  output logic                               s0_wbd_cyc_o,
  output logic                               s0_wbd_stb_o,

  // Slave 1 for UART
  input  logic [wb_bus_pkg::WB_DAT_W-1:0]    s1_wbd_dat_i,
  input  logic                               s1_wbd_ack_i,
  output logic [wb_bus_pkg::WB_DAT_W-1:0]    s1_wbd_dat_o,
  output logic [wb_map_pkg::S_ADR_W_REG-1:0] s1_wbd_adr_o,
  output logic [wb_bus_pkg::WB_SEL_W-1:0]    s1_wbd_sel_o,
  output logic                               s1_wbd_we_o,
  output logic                               s1_wbd_cyc_o,
  output logic                               s1_wbd_stb_o,

  // Slave 2 for PINMUX
  input  logic [wb_bus_pkg::WB_DAT_W-1:0]    s2_wbd_dat_i,
  input  logic                               s2_wbd_ack_i,
  output logic [wb_bus_pkg::WB_DAT_W-1:0]    s2_wbd_dat_o,
  output logic [wb_map_pkg::S_ADR_W_REG-1:0] s2_wbd_adr_o,
  output logic [wb_bus_pkg::WB_SEL_W-1:0]    s2_wbd_sel_o,
  output logic                               s2_wbd_we_o,
  output logic                               s2_wbd_cyc_o,
  output logic                               s2_wbd_stb_o,

  // Slave 3 for MBIST1
  input  logic [wb_bus_pkg::WB_DAT_W-1:0]      s3_wbd_dat_i,
  input  logic                                 s3_wbd_ack_i,
  output logic [wb_bus_pkg::WB_DAT_W-1:0]      s3_wbd_dat_o,
  output logic [wb_map_pkg::S_ADR_W_MBIST-1:0] s3_wbd_adr_o,
  output logic [wb_bus_pkg::WB_SEL_W-1:0]      s3_wbd_sel_o,
  output logic                                 s3_wbd_we_o,
  output logic                                 s3_wbd_cyc_o,
  output logic                                 s3_wbd_stb_o,

  // Slave 4 for MBIST2
  input  logic [wb_bus_pkg::WB_DAT_W-1:0]      s4_wbd_dat_i,
  input  logic                                 s4_wbd_ack_i,
  output logic [wb_bus_pkg::WB_DAT_W-1:0]      s4_wbd_dat_o,
  output logic [wb_map_pkg::S_ADR_W_MBIST-1:0] s4_wbd_adr_o,
  output logic [wb_bus_pkg::WB_SEL_W-1:0]      s4_wbd_sel_o,
  output logic                                 s4_wbd_we_o,
  output logic                                 s4_wbd_cyc_o,
  output logic                                 s4_wbd_stb_o
);
  import wb_bus_pkg::*;
  import wb_map_pkg::*;

  // Master side arrays
  logic [WB_DAT_W-1:0]    m_dat [NUM_MASTERS];
  logic [WB_ADR_W-1:0]    m_adr [NUM_MASTERS];
  logic [WB_SEL_W-1:0]    m_sel [NUM_MASTERS];
  logic [WB_TID_W-1:0]    m_tid [NUM_MASTERS];
  logic [WB_DAT_W-1:0]    m_rdat [NUM_MASTERS];
  logic [NUM_MASTERS-1:0] m_we;
  logic [NUM_MASTERS-1:0] m_cyc;
  logic [NUM_MASTERS-1:0] m_stb;
  logic [NUM_MASTERS-1:0] m_ack;

  // Slave side arrays, indexed by target id
  logic [WB_DAT_W-1:0]   s_rdat [WB_NUM_TGT];
  logic [WB_DAT_W-1:0]   s_dat [WB_NUM_TGT];
  logic [WB_ADR_W-1:0]   s_adr [WB_NUM_TGT];
  logic [WB_SEL_W-1:0]   s_sel [WB_NUM_TGT];
  logic [WB_NUM_TGT-1:0] s_ack;
  logic [WB_NUM_TGT-1:0] s_we;
  logic [WB_NUM_TGT-1:0] s_cyc;
  logic [WB_NUM_TGT-1:0] s_stb;

  // Before and after the staging registers
  wb_chan_if m_bus ();
  wb_chan_if s_bus ();

  // ----------------------------------------------------------
  // Master ports and address decode
  // ----------------------------------------------------------

  assign m_dat = '{m0_wbd_dat_i, m1_wbd_dat_i, m2_wbd_dat_i};
  assign m_adr = '{m0_wbd_adr_i, m1_wbd_adr_i, m2_wbd_adr_i};
  assign m_sel = '{m0_wbd_sel_i, m1_wbd_sel_i, m2_wbd_sel_i};
  assign m_we  = {m2_wbd_we_i, m1_wbd_we_i, m0_wbd_we_i};
  assign m_cyc = {m2_wbd_cyc_i, m1_wbd_cyc_i, m0_wbd_cyc_i};
  assign m_stb = {m2_wbd_stb_i, m1_wbd_stb_i, m0_wbd_stb_i};

  // Host keeps the plain map, RISC ports honour the boot remap
  for (genvar i = 0; i < NUM_MASTERS; i++) begin : g_dec
    wb_addr_decode #(
      .REMAP_EN (i != 0)
    ) wb_addr_decode_inst (
      .adr_i        (m_adr[i]),
      .boot_remap_i (boot_remap_i),
      .tid_o        (m_tid[i])
    );
  end

  assign m0_wbd_dat_o = m_rdat[0];
  assign m0_wbd_ack_o = m_ack[0];
  assign m1_wbd_dat_o = m_rdat[1];
  assign m1_wbd_ack_o = m_ack[1];
  assign m2_wbd_dat_o = m_rdat[2];
  assign m2_wbd_ack_o = m_ack[2];

  // ----------------------------------------------------------
  // Arbitration, staging and slave routing
  // ----------------------------------------------------------

  wb_master_sel #(
    .NUM_MASTERS (NUM_MASTERS)
  ) wb_master_sel_inst (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .m_dat_i  (m_dat),
    .m_adr_i  (m_adr),
    .m_sel_i  (m_sel),
    .m_we_i   (m_we),
    .m_cyc_i  (m_cyc),
    .m_stb_i  (m_stb),
    .m_tid_i  (m_tid),
    .m_rdat_o (m_rdat),
    .m_ack_o  (m_ack),
    .m_bus    (m_bus.initiator)
  );

  wb_stage wb_stage_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .m_bus   (m_bus.target),
    .s_bus   (s_bus.initiator)
  );

  wb_slave_sel wb_slave_sel_inst (
    .s_bus    (s_bus.target),
    .s_rdat_i (s_rdat),
    .s_ack_i  (s_ack),
    .s_dat_o  (s_dat),
    .s_adr_o  (s_adr),
    .s_sel_o  (s_sel),
    .s_we_o   (s_we),
    .s_cyc_o  (s_cyc),
    .s_stb_o  (s_stb)
  );

  // ----------------------------------------------------------
  // Slave ports with trimmed addresses
  // ----------------------------------------------------------

  assign s_rdat = '{s0_wbd_dat_i, s1_wbd_dat_i, s2_wbd_dat_i, s3_wbd_dat_i, s4_wbd_dat_i};
  assign s_ack  = {s4_wbd_ack_i, s3_wbd_ack_i, s2_wbd_ack_i, s1_wbd_ack_i, s0_wbd_ack_i};

  assign s0_wbd_dat_o = s_dat[TGT_QSPI];
  assign s0_wbd_adr_o = s_adr[TGT_QSPI];
  assign s0_wbd_sel_o = s_sel[TGT_QSPI];
  assign s0_wbd_we_o  = s_we[TGT_QSPI];
  assign s0_wbd_cyc_o = s_cyc[TGT_QSPI];
  assign s0_wbd_stb_o = s_stb[TGT_QSPI];

  // Register blocks decode only the low byte
  assign s1_wbd_dat_o = s_dat[TGT_UART];
  assign s1_wbd_adr_o = s_adr[TGT_UART][S_ADR_W_REG-1:0];
  assign s1_wbd_sel_o = s_sel[TGT_UART];
  assign s1_wbd_we_o  = s_we[TGT_UART];
  assign s1_wbd_cyc_o = s_cyc[TGT_UART];
  assign s1_wbd_stb_o = s_stb[TGT_UART];

  assign s2_wbd_dat_o = s_dat[TGT_PINMUX];
  assign s2_wbd_adr_o = s_adr[TGT_PINMUX][S_ADR_W_REG-1:0];
  assign s2_wbd_sel_o = s_sel[TGT_PINMUX];
  assign s2_wbd_we_o  = s_we[TGT_PINMUX];
  assign s2_wbd_cyc_o = s_cyc[TGT_PINMUX];
  assign s2_wbd_stb_o = s_stb[TGT_PINMUX];

  // MBIST memories span one 2 KB page
  assign s3_wbd_dat_o = s_dat[TGT_MBIST1];
  assign s3_wbd_adr_o = s_adr[TGT_MBIST1][S_ADR_W_MBIST-1:0];
  assign s3_wbd_sel_o = s_sel[TGT_MBIST1];
  assign s3_wbd_we_o  = s_we[TGT_MBIST1];
  assign s3_wbd_cyc_o = s_cyc[TGT_MBIST1];
  assign s3_wbd_stb_o = s_stb[TGT_MBIST1];

  assign s4_wbd_dat_o = s_dat[TGT_MBIST2];
  assign s4_wbd_adr_o = s_adr[TGT_MBIST2][S_ADR_W_MBIST-1:0];
  assign s4_wbd_sel_o = s_sel[TGT_MBIST2];
  assign s4_wbd_we_o  = s_we[TGT_MBIST2];
  assign s4_wbd_cyc_o = s_cyc[TGT_MBIST2];
  assign s4_wbd_stb_o = s_stb[TGT_MBIST2];

endmodule

// ==== logic/wb_map_pkg.sv ====
package wb_map_pkg;

  // ----------------------------------------------------------
  // Target ids
  // ----------------------------------------------------------

  // QSPI memory and QSPI registers both answer on target 0
  localparam logic [wb_bus_pkg::WB_TID_W-1:0] TGT_QSPI   = 3'd0;
  localparam logic [wb_bus_pkg::WB_TID_W-1:0] TGT_UART   = 3'd1;
  localparam logic [wb_bus_pkg::WB_TID_W-1:0] TGT_PINMUX = 3'd2;
  localparam logic [wb_bus_pkg::WB_TID_W-1:0] TGT_MBIST1 = 3'd3;
  localparam logic [wb_bus_pkg::WB_TID_W-1:0] TGT_MBIST2 = 3'd4;

  localparam int WB_NUM_TGT = 5;

  // ----------------------------------------------------------
  // Regions matched on address bits 31 to 16
  // ----------------------------------------------------------

  // QSPI memory is anything with a zero top nibble
  localparam logic [15:0] REG_QSPI_REG = 16'h1000;
  localparam logic [15:0] REG_UART     = 16'h1001;
  localparam logic [15:0] REG_PINMUX   = 16'h1002;
  localparam logic [15:0] REG_MBIST1   = 16'h1003;
  localparam logic [15:0] REG_MBIST2   = 16'h1004;

  // One remap bit per MBIST page
  localparam int REMAP_W = 2;

  // Address bits kept for the narrow slaves
  localparam int S_ADR_W_REG   = 8;
  localparam int S_ADR_W_MBIST = 11;

  // One address word seen through the region map or the boot remap pages
  typedef union packed {
    struct packed {
      logic [15:0] region;
      logic [15:0] offset;
    } reg_v;
    // Pages are the size of one MBIST memory
    struct packed {
      logic [20:0]              page;
      logic [S_ADR_W_MBIST-1:0] offset;
    } remap_v;
  } wb_addr_u;

endpackage

// ==== logic/wb_master_sel.sv ====
`timescale 1ns/100ps

module wb_master_sel #(
  parameter int  NUM_MASTERS = wb_bus_pkg::WB_NUM_MST,
  localparam int GNT_W       = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1
) (
  input  logic                          clk_i,
  input  logic                          reset_i,
  // Per master request fields
  input  logic [wb_bus_pkg::WB_DAT_W-1:0] m_dat_i [NUM_MASTERS],
  input  logic [wb_bus_pkg::WB_ADR_W-1:0] m_adr_i [NUM_MASTERS],
  input  logic [wb_bus_pkg::WB_SEL_W-1:0] m_sel_i [NUM_MASTERS],
  input  logic [NUM_MASTERS-1:0]          m_we_i,
  input  logic [NUM_MASTERS-1:0]          m_cyc_i,
  input  logic [NUM_MASTERS-1:0]          m_stb_i,
  input  logic [wb_bus_pkg::WB_TID_W-1:0] m_tid_i [NUM_MASTERS],
  // Per master response
  output logic [wb_bus_pkg::WB_DAT_W-1:0] m_rdat_o [NUM_MASTERS],
  output logic [NUM_MASTERS-1:0]          m_ack_o,
  // Arbitrated channel toward the stage
  wb_chan_if.initiator                    m_bus
);
  import wb_bus_pkg::*;

  logic [NUM_MASTERS-1:0] req;
  logic [GNT_W-1:0]       gnt;

  // Strobe still open and not yet acked
  assign req = m_stb_i & ~m_ack_o;

  wb_arb #(
    .NUM_MASTERS (NUM_MASTERS)
  ) wb_arb_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (req),
    .gnt_o   (gnt)
  );

  // ----------------------------------------------------------
  // Granted master onto the shared channel
  // ----------------------------------------------------------

  assign m_bus.dat = m_dat_i[gnt];
  // Slaves are word addressed
  assign m_bus.adr = {m_adr_i[gnt][WB_ADR_W-1:2], 2'b00};
  assign m_bus.sel = m_sel_i[gnt];
  assign m_bus.we  = m_we_i[gnt];
  assign m_bus.cyc = m_cyc_i[gnt];
  assign m_bus.stb = m_stb_i[gnt];
  assign m_bus.tid = m_tid_i[gnt];

  // ----------------------------------------------------------
  // Response back to the granted master only
  // ----------------------------------------------------------

  always_comb begin
    for (int i = 0; i < NUM_MASTERS; i++) begin
      m_ack_o[i]  = m_bus.ack && gnt == GNT_W'(i);
      // Idle masters read zero
      m_rdat_o[i] = (gnt == GNT_W'(i)) ? m_bus.rdat : '0;
    end
  end

endmodule

// ==== logic/wb_slave_sel.sv ====
`timescale 1ns/100ps

module wb_slave_sel (
  // Staged request
  wb_chan_if.target                         s_bus,
  // Slave responses
  input  logic [wb_bus_pkg::WB_DAT_W-1:0]   s_rdat_i [wb_map_pkg::WB_NUM_TGT],
  input  logic [wb_map_pkg::WB_NUM_TGT-1:0] s_ack_i,
  // Per slave request fields
  output logic [wb_bus_pkg::WB_DAT_W-1:0]   s_dat_o [wb_map_pkg::WB_NUM_TGT],
  output logic [wb_bus_pkg::WB_ADR_W-1:0]   s_adr_o [wb_map_pkg::WB_NUM_TGT],
  output logic [wb_bus_pkg::WB_SEL_W-1:0]   s_sel_o [wb_map_pkg::WB_NUM_TGT],
  output logic [wb_map_pkg::WB_NUM_TGT-1:0] s_we_o,
  output logic [wb_map_pkg::WB_NUM_TGT-1:0] s_cyc_o,
  output logic [wb_map_pkg::WB_NUM_TGT-1:0] s_stb_o
);
  import wb_bus_pkg::*;
  import wb_map_pkg::*;

  logic [WB_NUM_TGT-1:0] sel_oh;

  // Target id to one-hot slave select
  always_comb begin
    for (int t = 0; t < WB_NUM_TGT; t++) begin
      sel_oh[t] = (s_bus.tid == WB_TID_W'(t));
    end
  end

  // Only the selected slave sees a live request
  always_comb begin
    for (int t = 0; t < WB_NUM_TGT; t++) begin
      s_dat_o[t] = sel_oh[t] ? s_bus.dat : '0;
      s_adr_o[t] = sel_oh[t] ? s_bus.adr : '0;
      s_sel_o[t] = sel_oh[t] ? s_bus.sel : '0;
      s_we_o[t]  = sel_oh[t] && s_bus.we;
      s_cyc_o[t] = sel_oh[t] && s_bus.cyc;
      s_stb_o[t] = sel_oh[t] && s_bus.stb;
    end
  end

  // Selected slave response back to the stage
  always_comb begin
    s_bus.rdat = '0;
    s_bus.ack  = 1'b0;
    for (int t = 0; t < WB_NUM_TGT; t++) begin
      if (sel_oh[t]) begin
        s_bus.rdat = s_rdat_i[t];
        s_bus.ack  = s_ack_i[t];
      end
    end
  end

endmodule

// ==== logic/wb_stage.sv ====
`timescale 1ns/100ps

module wb_stage (
  input logic          clk_i,
  input logic          reset_i,
  // Master side channel, answered here
  wb_chan_if.target    m_bus,
  // Slave side channel, driven from registers
  wb_chan_if.initiator s_bus
);

  // Request taken and master ack not yet sent
  logic busy_q;
  logic capture;
  logic s_done;

  assign capture = !busy_q && m_bus.cyc && m_bus.stb;
  // Slave has finished the registered request
  assign s_done  = s_bus.stb && s_bus.ack;

  // ----------------------------------------------------------
  // Handshake control
  // ----------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q    <= 1'b0;
      s_bus.cyc <= 1'b0;
      s_bus.stb <= 1'b0;
      m_bus.ack <= 1'b0;
    end else begin
      // Master ack is a single pulse
      m_bus.ack <= 1'b0;
      if (capture) begin
        busy_q    <= 1'b1;
        s_bus.cyc <= 1'b1;
        s_bus.stb <= 1'b1;
      end else if (s_done) begin
        s_bus.cyc <= 1'b0;
        s_bus.stb <= 1'b0;
        m_bus.ack <= 1'b1;
      end else if (m_bus.ack) begin
        // Free again once the master has its ack
        busy_q <= 1'b0;
      end
    end
  end

  // ----------------------------------------------------------
  // Payload registers
  // ----------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (capture) begin
      s_bus.dat <= m_bus.dat;
      s_bus.adr <= m_bus.adr;
      s_bus.sel <= m_bus.sel;
      s_bus.we  <= m_bus.we;
      s_bus.tid <= m_bus.tid;
    end
    // Read data returns alongside the master ack
    if (s_done) begin
      m_bus.rdat <= s_bus.rdat;
    end
  end

endmodule

// ==== sim.f ====
logic/wb_bus_pkg.sv
logic/wb_map_pkg.sv
logic/wb_chan_if.sv
logic/wb_addr_decode.sv
logic/wb_arb.sv
logic/wb_master_sel.sv
logic/wb_stage.sv
logic/wb_slave_sel.sv
logic/wb_interconnect.sv
verif/tb_wb_interconnect.sv

// ==== verif/tb_wb_interconnect.sv ====
`timescale 1ns/100ps

module tb_wb_interconnect;

  logic clk;
  logic reset;
  logic [1:0] boot_remap;

  // Master side, index is the master number
  logic [2:0][31:0] m_adr;
  logic [2:0][31:0] m_wdat;
  logic [2:0][3:0]  m_sel;
  logic [2:0]       m_we;
  logic [2:0]       m_cyc;
  logic [2:0]       m_stb;
  wire  [2:0][31:0] m_rdat;
  wire  [2:0]       m_ack;

  // Slave side, index is the target id
  logic [4:0][31:0] s_rdat = '0;
  logic [4:0]       s_ack = '0;
  wire  [4:0][31:0] s_wdat;
  wire  [4:0][31:0] s_adr;
  wire  [4:0][3:0]  s_sel;
  wire  [4:0]       s_we;
  wire  [4:0]       s_cyc;
  wire  [4:0]       s_stb;

  // Golden vectors, one entry per file line
  logic [31:0] g_mst[$], g_remap[$], g_we[$], g_adr[$], g_wdat[$];
  logic [31:0] g_sel[$], g_tgt[$], g_sadr[$], g_rdat[$];

  // Transfers seen at the slave ports, in bus order
  int          ev_tgt_q[$];
  logic [31:0] ev_adr_q[$], ev_wdat_q[$];
  logic [3:0]  ev_sel_q[$];
  logic        ev_we_q[$];
  logic [4:0]  ev_mask_q[$];
  logic [4:0]  strobe_seen;

  // Slave model state
  logic [31:0]     seed = 32'h37f35129;
  logic [4:0][1:0] dly;
  logic [4:0][1:0] cnt;

  int cycles = 0;
  int cycle_limit = 200;

  // Narrow slave addresses widened for the models
  assign s_adr[1][31:8]  = '0;
  assign s_adr[2][31:8]  = '0;
  assign s_adr[3][31:11] = '0;
  assign s_adr[4][31:11] = '0;

  wb_interconnect wb_interconnect_inst (
    .clk_i (clk), .reset_i (reset), .boot_remap_i (boot_remap),
    .m0_wbd_dat_i (m_wdat[0]), .m0_wbd_adr_i (m_adr[0]), .m0_wbd_sel_i (m_sel[0]),
    .m0_wbd_we_i (m_we[0]), .m0_wbd_cyc_i (m_cyc[0]), .m0_wbd_stb_i (m_stb[0]),
    .m0_wbd_dat_o (m_rdat[0]), .m0_wbd_ack_o (m_ack[0]),
    .m1_wbd_dat_i (m_wdat[1]), .m1_wbd_adr_i (m_adr[1]), .m1_wbd_sel_i (m_sel[1]),
    .m1_wbd_we_i (m_we[1]), .m1_wbd_cyc_i (m_cyc[1]), .m1_wbd_stb_i (m_stb[1]),
    .m1_wbd_dat_o (m_rdat[1]), .m1_wbd_ack_o (m_ack[1]),
    .m2_wbd_dat_i (m_wdat[2]), .m2_wbd_adr_i (m_adr[2]), .m2_wbd_sel_i (m_sel[2]),
    .m2_wbd_we_i (m_we[2]), .m2_wbd_cyc_i (m_cyc[2]), .m2_wbd_stb_i (m_stb[2]),
    .m2_wbd_dat_o (m_rdat[2]), .m2_wbd_ack_o (m_ack[2]),
    .s0_wbd_dat_i (s_rdat[0]), .s0_wbd_ack_i (s_ack[0]), .s0_wbd_dat_o (s_wdat[0]),
    .s0_wbd_adr_o (s_adr[0]), .s0_wbd_sel_o (s_sel[0]), .s0_wbd_we_o (s_we[0]),
    .s0_wbd_cyc_o (s_cyc[0]), .s0_wbd_stb_o (s_stb[0]),
    .s1_wbd_dat_i (s_rdat[1]), .s1_wbd_ack_i (s_ack[1]), .s1_wbd_dat_o (s_wdat[1]),
    .s1_wbd_adr_o (s_adr[1][7:0]), .s1_wbd_sel_o (s_sel[1]), .s1_wbd_we_o (s_we[1]),
    .s1_wbd_cyc_o (s_cyc[1]), .s1_wbd_stb_o (s_stb[1]),
    .s2_wbd_dat_i (s_rdat[2]), .s2_wbd_ack_i (s_ack[2]), .s2_wbd_dat_o (s_wdat[2]),
    .s2_wbd_adr_o (s_adr[2][7:0]), .s2_wbd_sel_o (s_sel[2]), .s2_wbd_we_o (s_we[2]),
    .s2_wbd_cyc_o (s_cyc[2]), .s2_wbd_stb_o (s_stb[2]),
    .s3_wbd_dat_i (s_rdat[3]), .s3_wbd_ack_i (s_ack[3]), .s3_wbd_dat_o (s_wdat[3]),
    .s3_wbd_adr_o (s_adr[3][10:0]), .s3_wbd_sel_o (s_sel[3]), .s3_wbd_we_o (s_we[3]),
    .s3_wbd_cyc_o (s_cyc[3]), .s3_wbd_stb_o (s_stb[3]),
    .s4_wbd_dat_i (s_rdat[4]), .s4_wbd_ack_i (s_ack[4]), .s4_wbd_dat_o (s_wdat[4]),
    .s4_wbd_adr_o (s_adr[4][10:0]), .s4_wbd_sel_o (s_sel[4]), .s4_wbd_we_o (s_we[4]),
    .s4_wbd_cyc_o (s_cyc[4]), .s4_wbd_stb_o (s_stb[4])
  );

  always #2 clk = ~clk;

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] exp_v, input logic [31:0] act_v);
    if (act_v !== exp_v) begin
      abort_run($sformatf("ERR t=%0t %s expected=%h actual=%h", $time, name, exp_v, act_v));
    end
  endtask

  task automatic load_golden();
    int fd;
    string line;
    logic [31:0] mst, rmp, we, adr, wd, sel, tgt, sadr, rd;
    fd = $fopen("verif/wb_golden.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open verif/wb_golden.txt");
    end
    while ($fgets(line, fd) != 0) begin
      // Skip comments and blank lines
      if (line.len() > 1 && line[0] != "#") begin
        if ($sscanf(line, "%h %h %h %h %h %h %h %h %h",
                    mst, rmp, we, adr, wd, sel, tgt, sadr, rd) != 9) begin
          abort_run({"malformed golden line ", line});
        end
        g_mst.push_back(mst);
        g_remap.push_back(rmp);
        g_we.push_back(we);
        g_adr.push_back(adr);
        g_wdat.push_back(wd);
        g_sel.push_back(sel);
        g_tgt.push_back(tgt);
        g_sadr.push_back(sadr);
        g_rdat.push_back(rd);
      end
    end
    $fclose(fd);
  endtask

  // Raise one master's request, called on a rising edge
  task automatic issue(input int i);
    int m;
    m = g_mst[i];
    boot_remap <= g_remap[i][1:0];
    m_adr[m]   <= g_adr[i];
    m_wdat[m]  <= g_wdat[i];
    m_sel[m]   <= g_sel[i][3:0];
    m_we[m]    <= g_we[i][0];
    m_cyc[m]   <= 1'b1;
    m_stb[m]   <= 1'b1;
  endtask

  // Wait for the master ack, then match the slave side transfer
  task automatic complete(input int i);
    int m;
    int waited;
    int tgt;
    logic [2:0] own;
    m = g_mst[i];
    own = 3'b001 << m;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > 40) begin
        abort_run($sformatf("no ack within limit for vector %0d on master %0d", i, m));
      end
      // Only the issuing master may see ack
      check("m_wbd_ack_o of other masters", 0, m_ack & ~own);
    end while (!m_ack[m]);
    m_cyc[m] <= 1'b0;
    m_stb[m] <= 1'b0;
    if (!g_we[i][0]) begin
      check($sformatf("m%0d_wbd_dat_o", m), g_rdat[i], m_rdat[m]);
    end
    if (ev_tgt_q.size() == 0) begin
      abort_run($sformatf("master %0d acked with no slave transfer", m));
    end
    tgt = ev_tgt_q.pop_front();
    check("slave target id", g_tgt[i], tgt);
    check("slaves with cyc or stb", 32'd1 << g_tgt[i], ev_mask_q.pop_front());
    check($sformatf("s%0d_wbd_adr_o", tgt), g_sadr[i], ev_adr_q.pop_front());
    check($sformatf("s%0d_wbd_dat_o", tgt), g_wdat[i], ev_wdat_q.pop_front());
    check($sformatf("s%0d_wbd_sel_o", tgt), g_sel[i], ev_sel_q.pop_front());
    check($sformatf("s%0d_wbd_we_o", tgt), g_we[i], ev_we_q.pop_front());
  endtask

  // ----------------------------------------------------------
  // Slave models and bus monitor
  // ----------------------------------------------------------

  // Ack after a random 0 to 3 cycle delay, one cycle wide
  always @(posedge clk) begin
    if (reset) begin
      s_ack <= '0;
      for (int t = 0; t < 5; t++) begin
        seed = lcg_next(seed);
        dly[t] <= seed[17:16];
        cnt[t] <= '0;
      end
    end else begin
      for (int t = 0; t < 5; t++) begin
        if (s_ack[t]) begin
          s_ack[t] <= 1'b0;
        end else if (s_cyc[t] && s_stb[t]) begin
          if (cnt[t] == dly[t]) begin
            s_ack[t]  <= 1'b1;
            // Target id on top, word address below
            s_rdat[t] <= {4'(t), s_adr[t][27:0]};
            cnt[t]    <= '0;
            seed = lcg_next(seed);
            dly[t] <= seed[17:16];
          end else begin
            cnt[t] <= cnt[t] + 2'd1;
          end
        end
      end
    end
  end

  // Record each completed slave transfer with every slave that was strobed
  always @(posedge clk) begin
    if (reset) begin
      strobe_seen = '0;
    end else begin
      strobe_seen = strobe_seen | s_cyc | s_stb;
      for (int t = 0; t < 5; t++) begin
        if (s_stb[t] && s_ack[t]) begin
          ev_tgt_q.push_back(t);
          ev_adr_q.push_back(s_adr[t]);
          ev_wdat_q.push_back(s_wdat[t]);
          ev_sel_q.push_back(s_sel[t]);
          ev_we_q.push_back(s_we[t]);
          ev_mask_q.push_back(strobe_seen);
          strobe_seen = '0;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      abort_run("run exceeded its cycle limit");
    end
  end

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    boot_remap = '0;
    m_adr      = '0;
    m_wdat     = '0;
    m_sel      = '0;
    m_we       = '0;
    m_cyc      = '0;
    m_stb      = '0;
    load_golden();
    if (g_mst.size() < 3) begin
      abort_run("golden file holds fewer than three vectors");
    end
    cycle_limit = 40 * g_mst.size() + 200;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    // Nothing strobed or acked coming out of reset
    check("s_wbd_cyc_o", 0, s_cyc);
    check("s_wbd_stb_o", 0, s_stb);
    check("m_wbd_ack_o", 0, m_ack);
    // First three vectors contend in the same cycle
    for (int i = 0; i < 3; i++) begin
      issue(i);
    end
    complete(0);
    // First master asks again while the other two still wait
    // Round robin serves both of them before its second turn
    @(posedge clk);
    issue(0);
    complete(1);
    complete(2);
    complete(0);
    // Rest run one at a time
    for (int i = 3; i < g_mst.size(); i++) begin
      @(posedge clk);
      issue(i);
      complete(i);
    end
    check("unmatched slave transfers", 0, ev_tgt_q.size());
    $display("all tests passed");
    $finish;
  end

endmodule

// ==== verif/wb_golden.txt ====
# master remap we address wdata sel | expect: target slave_adr rdata (rdata on reads only)
# first three lines are m0 m1 m2 starting in the same cycle for round robin order
0 0 0 10010004 00000000 f 1 00000004 10000004
1 0 0 10020013 00000000 f 2 00000010 20000010
2 0 0 10030126 00000000 f 3 00000124 30000124
0 0 0 00001234 00000000 f 0 00001234 00001234
0 0 1 0abcdef8 12345678 f 0 0abcdef8 00000000
0 0 0 10000040 00000000 f 0 10000040 00000040
0 0 1 100100ff a5a5a5a5 1 1 000000fc 00000000
0 0 0 10020088 00000000 f 2 00000088 20000088
0 0 1 10030ffc deadbeef 3 3 000007fc 00000000
0 0 0 10040802 00000000 f 4 00000000 40000000
0 0 0 10047abc 00000000 f 4 000002bc 400002bc
0 0 0 20000010 00000000 f 0 20000010 00000010
2 0 0 10050000 00000000 f 0 10050000 00050000
1 0 0 fffffffc 00000000 f 0 fffffffc 0ffffffc
1 1 0 00000100 00000000 f 3 00000100 30000100
2 1 1 000007f8 0badf00d c 3 000007f8 00000000
2 2 0 00000804 00000000 f 4 00000004 40000004
1 3 0 00000ffc 00000000 f 4 000007fc 400007fc
1 3 0 00001000 00000000 f 0 00001000 00001000
0 3 0 00000100 00000000 f 0 00000100 00000100
0 3 0 00000804 00000000 f 0 00000804 00000804
1 2 0 00000100 00000000 f 0 00000100 00000100
2 1 0 00000804 00000000 f 0 00000804 00000804
1 0 1 10010010 00c0ffee 2 1 00000010 00000000
2 0 1 10020004 13579bdf 8 2 00000004 00000000
0 0 1 10040400 2468ace0 f 4 00000400 00000000
2 0 0 10010008 00000000 f 1 00000008 10000008
